/* all.f */
cache_types.sv
cache_array.sv
cache_tag_compare.sv
cache_line_merge.sv
cache_mem_address.sv
cache_datapath.sv
cache_control.sv
cache.sv
cache_tb.sv

/* cache.sv */
`timescale 1ns/1ps

module cache (
    input  logic                    clk,
    input  logic                    reset,
    input  cache_types::cpu_req_t   cpu_req,
    input  cache_types::lc3b_c_line mem_datain,
    input  logic                    mem_resp,
    output logic                    cpu_resp,
    output cache_types::lc3b_c_line cpu_dataout,
    output cache_types::mem_req_t   mem_req
);

    import cache_types::*;

    cache_ctrl_t   ctrl;
    cache_status_t status;
    logic          mem_read;
    logic          mem_write;
    lc3b_word      mem_address;
    lc3b_c_line    mem_wdata;

    cache_control u_control (
        .clk,
        .reset,
        .status    (status),
        .cpu_read  (cpu_req.read),
        .cpu_write (cpu_req.write),
        .mem_resp  (mem_resp),
        .ctrl      (ctrl),
        .mem_read  (mem_read),
        .mem_write (mem_write)
    );

    cache_datapath u_datapath (
        .clk,
        .reset,
        .ctrl        (ctrl),
        .cpu_req     (cpu_req),
        .mem_datain  (mem_datain),
        .status      (status),
        .cpu_resp    (cpu_resp),
        .cpu_dataout (cpu_dataout),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata)
    );

    assign mem_req.address = mem_address;
    assign mem_req.wdata   = mem_wdata;
    assign mem_req.read    = mem_read;
    assign mem_req.write   = mem_write;

endmodule : cache

/* cache_array.sv */
`timescale 1ns/1ps

module cache_array #(
    parameter type payload_t = logic
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     write,
    input  cache_types::lc3b_c_index index,
    input  payload_t                 datain,
    output payload_t                 dataout
);

    import cache_types::*;

    payload_t entries [num_sets];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_sets; i++) begin
                entries[i] <= '0;
            end
        end else if (write) begin
            entries[index] <= datain;
        end
    end

    // Read is combinational so the compare sees the set in the same cycle
    assign dataout = entries[index];

endmodule : cache_array

/* cache_control.sv */
`timescale 1ns/1ps

module cache_control (
    input  logic                       clk,
    input  logic                       reset,
    input  cache_types::cache_status_t status,
    input  logic                       cpu_read,
    input  logic                       cpu_write,
    input  logic                       mem_resp,
    output cache_types::cache_ctrl_t   ctrl,
    output logic                       mem_read,
    output logic                       mem_write
);

    typedef enum logic [1:0] {
        s_compare,
        s_writeback,
        s_reload
    } state_t;

    state_t state;
    state_t next_state;
    logic   request;

    assign request = cpu_read | cpu_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_compare;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            s_compare: begin
                if (request && !status.hit) begin
                    // Victim must reach memory before it is overwritten
                    next_state = status.dirty[status.lru] ? s_writeback : s_reload;
                end
            end
            s_writeback: begin
                if (mem_resp) begin
                    next_state = s_reload;
                end
            end
            s_reload: begin
                if (mem_resp) begin
                    next_state = s_compare;   // Rerun compare, which now hits
                end
            end
            default: next_state = s_compare;
        endcase
    end

    assign ctrl.hit_update = (state == s_compare) && request;
    assign ctrl.writeback  = (state == s_writeback);
    assign ctrl.reload     = (state == s_reload) && mem_resp;   // Fill at the response edge

    assign mem_read  = (state == s_reload);
    assign mem_write = (state == s_writeback);

    assert property (@(posedge clk) disable iff (reset) !(mem_read && mem_write))
        else $error("Memory read and write strobes high together");

    // Memory sees a held request until it answers
    assert property (@(posedge clk) disable iff (reset)
        (mem_read && !mem_resp) |=> mem_read)
        else $error("Memory read dropped before mem_resp");

    assert property (@(posedge clk) disable iff (reset)
        (mem_write && !mem_resp) |=> mem_write)
        else $error("Memory write dropped before mem_resp");

endmodule : cache_control

/* cache_datapath.sv */
`timescale 1ns/1ps

module cache_datapath (
    input  logic                       clk,
    input  logic                       reset,
    input  cache_types::cache_ctrl_t   ctrl,
    input  cache_types::cpu_req_t      cpu_req,
    input  cache_types::lc3b_c_line    mem_datain,
    output cache_types::cache_status_t status,
    output logic                       cpu_resp,
    output cache_types::lc3b_c_line    cpu_dataout,
    output cache_types::lc3b_word      mem_address,
    output cache_types::lc3b_c_line    mem_wdata
);

    import cache_types::*;

    lc3b_c_tag    cpu_tag;
    lc3b_c_index  cpu_index;
    lc3b_c_offset cpu_offset;

    logic [1:0] valid;
    logic [1:0] dirty;
    logic [1:0] match;
    logic [1:0] victim;
    logic [1:0] fill_we;
    logic [1:0] data_we;
    lc3b_c_tag  tag [2];
    lc3b_c_line line [2];
    logic       lru;
    logic       lru_we;
    logic       hit;
    lc3b_c_line hit_line;
    lc3b_c_line merged_line;

    assign cpu_tag    = cpu_req.address[word_width-1 -: tag_width];
    assign cpu_index  = cpu_req.address[offset_width +: index_width];
    assign cpu_offset = cpu_req.address[offset_width-1:0];

    assign victim = {lru, ~lru};

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign fill_we[w] = ctrl.reload & victim[w];
        // Dirty shares this enable, set on a write hit, cleared on a fill
        assign data_we[w] = fill_we[w] | (ctrl.hit_update & cpu_req.write & match[w]);

        cache_array #(.payload_t(logic)) u_valid (
            .clk,
            .reset,
            .write   (fill_we[w]),
            .index   (cpu_index),
            .datain  (1'b1),
            .dataout (valid[w])
        );

        cache_array #(.payload_t(lc3b_c_tag)) u_tag (
            .clk,
            .reset,
            .write   (fill_we[w]),
            .index   (cpu_index),
            .datain  (cpu_tag),
            .dataout (tag[w])
        );

        cache_array #(.payload_t(logic)) u_dirty (
            .clk,
            .reset,
            .write   (data_we[w]),
            .index   (cpu_index),
            .datain  (~ctrl.reload),
            .dataout (dirty[w])
        );

        cache_array #(.payload_t(lc3b_c_line)) u_data (
            .clk,
            .reset,
            .write   (data_we[w]),
            .index   (cpu_index),
            .datain  (merged_line),
            .dataout (line[w])
        );
    end

    assign lru_we = ctrl.hit_update & hit;

    cache_array #(.payload_t(logic)) u_lru (
        .clk,
        .reset,
        .write   (lru_we),
        .index   (cpu_index),
        .datain  (match[0]),           // Hit in way 0 leaves way 1 as victim
        .dataout (lru)
    );

    cache_tag_compare u_compare (
        .clk,
        .valid    (valid),
        .tag0     (tag[0]),
        .tag1     (tag[1]),
        .addr_tag (cpu_tag),
        .line0    (line[0]),
        .line1    (line[1]),
        .match    (match),
        .hit      (hit),
        .hit_line (hit_line)
    );

    cache_line_merge u_merge (
        .reload   (ctrl.reload),
        .offset   (cpu_offset),
        .wmask    (cpu_req.wmask),
        .wdata    (cpu_req.wdata),
        .mem_line (mem_datain),
        .hit_line (hit_line),
        .line_out (merged_line)
    );

    cache_mem_address u_mem_address (
        .writeback   (ctrl.writeback),
        .cpu_address (cpu_req.address),
        .victim_tag  (lru ? tag[1] : tag[0]),
        .mem_address (mem_address)
    );

    assign mem_wdata   = lru ? line[1] : line[0];
    assign cpu_dataout = hit_line;
    assign cpu_resp    = ctrl.hit_update & hit;

    assign status.hit   = hit;
    assign status.lru   = lru;
    assign status.dirty = dirty;

endmodule : cache_datapath

/* cache_line_merge.sv */
`timescale 1ns/1ps

module cache_line_merge (
    input  logic                      reload,
    input  cache_types::lc3b_c_offset offset,
    input  logic [1:0]                wmask,
    input  cache_types::lc3b_word     wdata,
    input  cache_types::lc3b_c_line   mem_line,
    input  cache_types::lc3b_c_line   hit_line,
    output cache_types::lc3b_c_line   line_out
);

    import cache_types::*;

    logic [2:0] word_sel;
    logic [6:0] low_bit;

    assign word_sel = offset[3:1];                  // Byte offset to word
    assign low_bit  = 7'(word_sel * word_width);

    always_comb begin
        line_out = hit_line;
        if (reload) begin
            line_out = mem_line;
        end else begin
            if (wmask[0]) begin
                line_out[low_bit +: 8] = wdata[7:0];
            end
            if (wmask[1]) begin
                line_out[low_bit + 7'd8 +: 8] = wdata[15:8];
            end
        end
    end

endmodule : cache_line_merge

/* cache_mem_address.sv */
`timescale 1ns/1ps

module cache_mem_address (
    input  logic                   writeback,
    input  cache_types::lc3b_word  cpu_address,
    input  cache_types::lc3b_c_tag victim_tag,
    output cache_types::lc3b_word  mem_address
);

    import cache_types::*;

    lc3b_c_tag   line_tag;
    lc3b_c_index line_index;

    assign line_tag   = writeback ? victim_tag : cpu_address[word_width-1 -: tag_width];
    assign line_index = cpu_address[offset_width +: index_width];

    // Whole-line transfers, offset always zero
    assign mem_address = {line_tag, line_index, {offset_width{1'b0}}};

endmodule : cache_mem_address

/* cache_tag_compare.sv */
`timescale 1ns/1ps

module cache_tag_compare (
    input  logic                    clk,
    input  logic [1:0]              valid,
    input  cache_types::lc3b_c_tag  tag0,
    input  cache_types::lc3b_c_tag  tag1,
    input  cache_types::lc3b_c_tag  addr_tag,
    input  cache_types::lc3b_c_line line0,
    input  cache_types::lc3b_c_line line1,
    output logic [1:0]              match,
    output logic                    hit,
    output cache_types::lc3b_c_line hit_line
);

    assign match[0] = valid[0] && (tag0 == addr_tag);
    assign match[1] = valid[1] && (tag1 == addr_tag);
    assign hit      = |match;

    // Way 0 line when nothing matches
    assign hit_line = match[1] ? line1 : line0;

    // A reload only fills on a miss, so one tag never lives in both ways
    assert property (@(posedge clk) !$isunknown(match) |-> (match != 2'b11))
        else $error("Both ways hold the tag %h", addr_tag);

endmodule : cache_tag_compare

/* cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

    import cache_types::*;

    localparam int clk_period    = 8;
    localparam int num_accesses  = 480;                  // Upper bound over all tests
    localparam int access_cycles = 2 * (4 + 2) + 4;      // Writeback, reload, compare
    localparam int watchdog_ns   = num_accesses * access_cycles * clk_period * 2;
    localparam int num_lines     = 1 << (word_width - offset_width);

    typedef struct packed {
        logic       write;
        lc3b_word   address;
        lc3b_c_line data;
    } mem_txn_t;

    logic       clk;
    logic       reset;
    cpu_req_t   cpu_req;
    lc3b_c_line mem_datain;
    logic       mem_resp;
    logic       cpu_resp;
    lc3b_c_line cpu_dataout;
    mem_req_t   mem_req;

    lc3b_c_line mem_image [num_lines];
    lc3b_word   shadow [1 << (word_width - 1)];    // One entry per word address
    mem_txn_t   txn_log [$];
    int         txn_seen;

    // Reference replacement state
    logic      ref_valid [num_sets][2];
    logic      ref_dirty [num_sets][2];
    lc3b_c_tag ref_tag [num_sets][2];
    logic      ref_lru [num_sets];

    int error_count;
    int check_count;
    int cmp_errors;
    int cmp_checks;
    int test_errors;
    int access_count;

    cache u_cache (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .mem_datain  (mem_datain),
        .mem_resp    (mem_resp),
        .cpu_resp    (cpu_resp),
        .cpu_dataout (cpu_dataout),
        .mem_req     (mem_req)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    function automatic lc3b_word init_word(lc3b_word addr);
        return (addr * 16'h9e37) ^ 16'h5ac3;
    endfunction

    function automatic lc3b_word expected_word(lc3b_word addr);
        return shadow[addr[15:1]];
    endfunction

    function automatic lc3b_c_line expected_line(lc3b_word addr);
        lc3b_c_line line;
        for (int k = 0; k < 8; k++) begin
            line[k * word_width +: word_width] = expected_word({addr[15:4], 3'(k), 1'b0});
        end
        return line;
    endfunction

    function automatic logic resident_dirty(lc3b_word addr);
        logic found;
        found = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[addr[6:4]][w] && ref_dirty[addr[6:4]][w]
                    && ref_tag[addr[6:4]][w] == addr[15:7]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // A hit turns LRU to the other way, a miss fills the LRU way
    task automatic model_access(input lc3b_word addr, input logic write, output logic hit,
                                output logic wb, output lc3b_word wb_addr);
        lc3b_c_index set;
        int          way;
        set     = addr[6:4];
        hit     = 1'b0;
        way     = int'(ref_lru[set]);
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == addr[15:7]) begin
                hit = 1'b1;
                way = w;
            end
        end
        wb      = !hit && ref_dirty[set][way];
        wb_addr = {ref_tag[set][way], set, 4'h0};
        if (!hit) begin
            ref_valid[set][way] = 1'b1;
            ref_dirty[set][way] = 1'b0;
            ref_tag[set][way]   = addr[15:7];
        end
        ref_lru[set] = (way == 0);
        if (write) begin
            ref_dirty[set][way] = 1'b1;
        end
    endtask

    task automatic check_traffic(lc3b_word addr, logic hit, logic wb, lc3b_word wb_addr);
        mem_txn_t txn;
        if (wb) begin
            check_count++;
            assert (txn_seen < txn_log.size() && txn_log[txn_seen].write) else begin
                $display("No memory writeback of victim %h before the reload of %h",
                         wb_addr, addr);
                error_count++;
            end
            if (txn_seen < txn_log.size() && txn_log[txn_seen].write) begin
                txn = txn_log[txn_seen];
                txn_seen++;
                check_count++;
                assert (txn.address == wb_addr && txn.data == expected_line(wb_addr)) else begin
                    $display("MISMATCH %0t: writeback to %h with %h, expected %h with %h",
                             $time, txn.address, txn.data, wb_addr, expected_line(wb_addr));
                    error_count++;
                end
            end
        end
        if (!hit) begin
            check_count++;
            assert (txn_seen < txn_log.size() && !txn_log[txn_seen].write
                    && txn_log[txn_seen].address == {addr[15:4], 4'h0}) else begin
                $display("MISMATCH %0t: no reload read of line %h for the miss at %h",
                         $time, {addr[15:4], 4'h0}, addr);
                error_count++;
            end
            txn_seen++;
        end
        check_count++;
        assert (txn_seen >= txn_log.size()) else begin
            $display("Memory strobe that does not belong to the %s at %h",
                     hit ? "hit" : "miss", addr);
            error_count++;
        end
        txn_seen = txn_log.size();
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic access(input lc3b_word addr, input logic write, input lc3b_word wdata,
                          input logic [1:0] mask, output int traffic);
        logic     hit;
        logic     wb;
        lc3b_word wb_addr;
        int       cycles;
        int       first_txn;
        model_access(addr, write, hit, wb, wb_addr);
        first_txn       = txn_log.size();
        cpu_req.address = addr;
        cpu_req.wdata   = wdata;
        cpu_req.read    = !write;
        cpu_req.write   = write;
        cpu_req.wmask   = write ? mask : 2'b00;
        cycles          = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cpu_resp);
        @(posedge clk);
        #1;
        cpu_req.read  = 1'b0;
        cpu_req.write = 1'b0;
        if (write) begin
            if (mask[0]) begin
                shadow[addr[15:1]][7:0] = wdata[7:0];
            end
            if (mask[1]) begin
                shadow[addr[15:1]][15:8] = wdata[15:8];
            end
        end
        traffic = txn_log.size() - first_txn;
        check_traffic(addr, hit, wb, wb_addr);
        check_count++;
        assert (!hit || cycles == 1) else begin
            $display("Hit at %h took %0d cycles instead of one", addr, cycles);
            error_count++;
        end
        access_count++;
    endtask

    task automatic expect_traffic(int traffic, int expected, string what);
        check_count++;
        assert (traffic == expected) else begin
            $display("%s: %0d memory transactions instead of %0d at %0t",
                     what, traffic, expected, $time);
            error_count++;
        end
    endtask

    task automatic end_test(string name);
        int errors;
        errors = error_count + cmp_errors - test_errors;
        $display("test %-14s %s, %0d errors", name, (errors == 0) ? "ok" : "FAILED", errors);
        test_errors = error_count + cmp_errors;
    endtask

    // Memory answers a held strobe after 1 to 4 cycles
    initial begin
        int       delay;
        mem_txn_t txn;
        mem_resp   = 1'b0;
        mem_datain = '0;
        for (int l = 0; l < num_lines; l++) begin
            for (int k = 0; k < 8; k++) begin
                mem_image[l][k * word_width +: word_width] = init_word({12'(l), 3'(k), 1'b0});
            end
        end
        forever begin
            @(negedge clk);
            if (!reset && (mem_req.read || mem_req.write)) begin
                delay = $urandom_range(4, 1);
                repeat (delay) @(posedge clk);
                #1;
                txn.write   = mem_req.write;
                txn.address = mem_req.address;
                txn.data    = mem_req.wdata;
                if (mem_req.write) begin
                    mem_image[mem_req.address[15:4]] = mem_req.wdata;
                end else begin
                    mem_datain = mem_image[mem_req.address[15:4]];
                    txn.data   = mem_datain;
                end
                txn_log.push_back(txn);
                mem_resp = 1'b1;
                @(posedge clk);
                #1;
                mem_resp = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        lc3b_word got;
        lc3b_word exp;
        if (!reset && cpu_resp && cpu_req.read) begin
            got = cpu_dataout[int'(cpu_req.address[3:1]) * word_width +: word_width];
            exp = expected_word(cpu_req.address);
            cmp_checks++;
            assert (got == exp && cpu_dataout == expected_line(cpu_req.address)) else begin
                $display("MISMATCH %0t: read %h gave word %h line %h, expected %h line %h",
                         $time, cpu_req.address, got, cpu_dataout, exp,
                         expected_line(cpu_req.address));
                cmp_errors++;
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, a request never got its response",
                 watchdog_ns);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int       traffic;
        lc3b_word a;
        lc3b_word base;
        void'($urandom(32'h4bc4_6ba5));
        reset = 1'b1;
        cpu_req = '0;
        for (int i = 0; i < (1 << (word_width - 1)); i++) begin
            shadow[i] = init_word({15'(i), 1'b0});
        end
        for (int s = 0; s < num_sets; s++) begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk);
        check_count++;
        assert (!cpu_resp && !mem_req.read && !mem_req.write) else begin
            $display("Response or memory strobe high right after reset");
            error_count++;
        end
        @(posedge clk);
        #1;
        for (int s = 0; s < num_sets; s++) begin
            access({9'(s + 3), 3'(s), 4'(2 * s)}, 1'b0, '0, 2'b00, traffic);
            expect_traffic(traffic, 1, "First access to a set");
        end
        end_test("reset_state");

        a = 16'h4a26;
        access(a, 1'b0, '0, 2'b00, traffic);
        expect_traffic(traffic, 1, "Read miss");
        access(a + 16'h0006, 1'b0, '0, 2'b00, traffic);
        expect_traffic(traffic, 0, "Reread of the same line");
        end_test("read_miss_hit");

        base = {9'h0a1, 3'd4, 4'h0};
        for (int k = 0; k < 8; k++) begin
            access(base + 16'(2 * k), 1'b1, 16'($urandom), 2'(1 + k % 3), traffic);
            access(base + 16'(2 * k), 1'b0, '0, 2'b00, traffic);
        end
        end_test("masked_writes");

        access({9'h011, 3'd6, 4'h0}, 1'b0, '0, 2'b00, traffic);     // A
        access({9'h022, 3'd6, 4'h0}, 1'b0, '0, 2'b00, traffic);     // B
        access({9'h011, 3'd6, 4'h2}, 1'b0, '0, 2'b00, traffic);
        access({9'h033, 3'd6, 4'h0}, 1'b0, '0, 2'b00, traffic);     // C replaces B
        access({9'h011, 3'd6, 4'h4}, 1'b0, '0, 2'b00, traffic);
        expect_traffic(traffic, 0, "Read of A after C");
        access({9'h022, 3'd6, 4'h0}, 1'b0, '0, 2'b00, traffic);
        expect_traffic(traffic, 1, "Read of B after C");
        end_test("lru_replace");

        a = {9'h101, 3'd7, 4'h6};
        access(a, 1'b1, 16'hbeef, 2'b11, traffic);
        access({9'h102, 3'd7, 4'h0}, 1'b0, '0, 2'b00, traffic);
        expect_traffic(traffic, 1, "Clean eviction");
        access({9'h103, 3'd7, 4'h0}, 1'b0, '0, 2'b00, traffic);
        expect_traffic(traffic, 2, "Dirty eviction");
        check_count++;
        assert (mem_image[a[15:4]] == expected_line(a)) else begin
            $display("MISMATCH %0t: memory line %h holds %h, expected %h",
                     $time, a, mem_image[a[15:4]], expected_line(a));
            error_count++;
        end
        access({9'h104, 3'd7, 4'h0}, 1'b0, '0, 2'b00, traffic);
        expect_traffic(traffic, 1, "Clean eviction");
        end_test("dirty_writeback");

        for (int n = 0; n < 400; n++) begin
            a = {9'h140 + 9'($urandom_range(3, 0)), 3'($urandom_range(2, 0)), 3'($urandom), 1'b0};
            access(a, 1'($urandom_range(1, 0)), 16'($urandom), 2'($urandom_range(3, 1)),
                   traffic);
        end
        // Lines held dirty are read back through the cache, the rest come from memory
        for (int t = 0; t < 4; t++) begin
            for (int s = 0; s < 3; s++) begin
                a = {9'h140 + 9'(t), 3'(s), 4'h0};
                if (resident_dirty(a)) begin
                    access(a, 1'b0, '0, 2'b00, traffic);
                end else begin
                    check_count++;
                    assert (mem_image[a[15:4]] == expected_line(a)) else begin
                        $display("MISMATCH %0t: memory line %h holds %h, expected %h",
                                 $time, a, mem_image[a[15:4]], expected_line(a));
                        error_count++;
                    end
                end
            end
        end
        end_test("random_mix");

        $display("%0d accesses, %0d checks, %0d errors", access_count,
                 check_count + cmp_checks, error_count + cmp_errors);
        if (error_count + cmp_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : cache_tb

/* cache_types.sv */
package cache_types;

    localparam int word_width   = 16;
    localparam int line_width   = 128;
    localparam int tag_width    = 9;   // Address bits 15..7
    localparam int index_width  = 3;   // Address bits 6..4
    localparam int offset_width = 4;   // Byte offset, 8 words per line
    localparam int num_sets     = 8;

    typedef logic [word_width-1:0]   lc3b_word;
    typedef logic [line_width-1:0]   lc3b_c_line;
    typedef logic [tag_width-1:0]    lc3b_c_tag;
    typedef logic [index_width-1:0]  lc3b_c_index;
    typedef logic [offset_width-1:0] lc3b_c_offset;

    typedef struct packed {
        lc3b_word   address;
        lc3b_word   wdata;
        logic       read;
        logic       write;
        logic [1:0] wmask;     // Bit 0 low byte, bit 1 high byte
    } cpu_req_t;

    typedef struct packed {
        lc3b_word   address;   // Line aligned
        lc3b_c_line wdata;
        logic       read;
        logic       write;
    } mem_req_t;

    typedef struct packed {
        logic reload;          // Memory line goes into the victim way
        logic writeback;       // Memory address points at the victim
        logic hit_update;      // LRU, dirty and data may update on a hit
    } cache_ctrl_t;

    typedef struct packed {
        logic       hit;
        logic       lru;       // Least recently used way
        logic [1:0] dirty;
    } cache_status_t;

endpackage : cache_types

/* run.sh */
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 --top-module cache_tb -f all.f -o cache_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/cache_sim | tee "$log"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$log"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0
